// ==== cpuPkg.sv ====
package cpuPkg;

	localparam int dataWidth = 16;

	// Jump conditions carried in the fun field of opJc
	localparam logic [2:0] condZero = 3'd0;
	localparam logic [2:0] condNeg = 3'd1;
	localparam logic [2:0] condCarry = 3'd2;

	typedef enum logic [4:0] {
		opNop = 5'd0,
		opAlu = 5'd1,
		opLdm = 5'd2,
		opLdd = 5'd3,
		opStd = 5'd4,
		opJc = 5'd5,
		opJmp = 5'd6
	} opcodeE;

	// Same encoding as the fun field; dst is the left operand
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluMov = 3'd4,
		aluNot = 3'd5
	} aluOpE;

	typedef enum logic [1:0] {
		fwdReg = 2'd0,
		fwdExMem = 2'd1,
		fwdMemWb = 2'd2
	} fwdSelE;

	// For opLdm the 7-bit immediate is {src, fun}
	typedef struct packed {
		opcodeE opcode;
		logic [3:0] src;
		logic [3:0] dst;
		logic [2:0] fun;
	} instrT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic immToAlu;
		logic updateFlags;
		logic branch;
		logic uncond;
		aluOpE aluOp;
	} ctrlT;

	typedef struct packed {
		logic z;
		logic n;
		logic c;
	} flagsT;

	typedef struct packed {
		ctrlT ctrl;
		logic [2:0] fun;
		logic [3:0] srcAddr;
		logic [3:0] dstAddr;
		logic [dataWidth-1:0] srcVal;
		logic [dataWidth-1:0] dstVal;
		logic [dataWidth-1:0] imm;
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic [3:0] dst;
		logic [dataWidth-1:0] aluResult;
		logic [dataWidth-1:0] storeData;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic [3:0] dst;
		logic [dataWidth-1:0] aluResult;
		logic [dataWidth-1:0] memData;
	} memWbT;

endpackage

// ==== pipeReg.sv ====
module pipeReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rstN,
	input logic bubble,
	input payloadT d,
	output payloadT q
);

	// Zero payload carries zero control, i.e. a NOP
	always_ff @(posedge clk) begin
		if (!rstN || bubble) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule

// ==== regFile.sv ====
module regFile (
	input logic clk,
	input logic rstN,
	input logic we,
	input logic [3:0] waddr,
	input logic [cpuPkg::dataWidth-1:0] wdata,
	input logic [3:0] raddrA,
	input logic [3:0] raddrB,
	output logic [cpuPkg::dataWidth-1:0] rdataA,
	output logic [cpuPkg::dataWidth-1:0] rdataB
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [16];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			regs <= '{default: '0};
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign rdataA = (we && waddr == raddrA) ? wdata : regs[raddrA];
	assign rdataB = (we && waddr == raddrB) ? wdata : regs[raddrB];

endmodule

// ==== controlUnit.sv ====
module controlUnit (
	input cpuPkg::instrT instr,
	input logic bubble,
	output cpuPkg::ctrlT ctrl
);
	import cpuPkg::*;

	always_comb begin
		ctrl = '0;
		if (!bubble) begin
			case (instr.opcode)
				opAlu: begin
					ctrl.regWrite = 1'b1;
					ctrl.updateFlags = 1'b1;
					ctrl.aluOp = aluOpE'(instr.fun);
				end
				opLdm: begin
					ctrl.regWrite = 1'b1;
					ctrl.immToAlu = 1'b1;
					ctrl.aluOp = aluMov;
				end
				// Address is the src value passed through the ALU
				opLdd: begin
					ctrl.regWrite = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.memToReg = 1'b1;
					ctrl.aluOp = aluMov;
				end
				opStd: begin
					ctrl.memWrite = 1'b1;
					ctrl.aluOp = aluMov;
				end
				opJc: begin
					ctrl.branch = 1'b1;
					ctrl.aluOp = aluMov;
				end
				opJmp: begin
					ctrl.branch = 1'b1;
					ctrl.uncond = 1'b1;
					ctrl.aluOp = aluMov;
				end
				default: begin
					ctrl = '0;
				end
			endcase
		end
	end

endmodule

// ==== hazardUnit.sv ====
module hazardUnit (
	input logic clk,
	input logic rstN,
	input logic [3:0] idSrc,
	input logic [3:0] idDst,
	input logic exMemRead,
	input logic [3:0] exDst,
	input logic [3:0] exSrc,
	input logic exMemRegWrite,
	input logic [3:0] exMemDst,
	input logic memWbRegWrite,
	input logic [3:0] memWbDst,
	output logic stall,
	output cpuPkg::fwdSelE fwdSrc,
	output cpuPkg::fwdSelE fwdDst
);
	import cpuPkg::*;

	// Newest producer wins, EX/MEM before MEM/WB
	function automatic fwdSelE pickSource(
		input logic [3:0] addr,
		input logic exMemWe,
		input logic [3:0] exMemAddr,
		input logic memWbWe,
		input logic [3:0] memWbAddr
	);
		return fwdSelE'((exMemWe && exMemAddr == addr) ? fwdExMem :
			(memWbWe && memWbAddr == addr) ? fwdMemWb : fwdReg);
	endfunction

	// Load data is not ready until MEM/WB, so hold decode one cycle
	assign stall = exMemRead && (exDst == idSrc || exDst == idDst);

	assign fwdSrc = pickSource(exSrc, exMemRegWrite, exMemDst, memWbRegWrite, memWbDst);
	assign fwdDst = pickSource(exDst, exMemRegWrite, exMemDst, memWbRegWrite, memWbDst);

	assert property (@(posedge clk) disable iff (!rstN) !$isunknown({fwdSrc, fwdDst}))
		else $error("forward select unknown");

endmodule

// ==== fetchStage.sv ====
module fetchStage #(
	parameter int imemDepth = 64
) (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic branchTaken,
	input logic [cpuPkg::dataWidth-1:0] branchTarget,
	input logic imemWe,
	input logic [$clog2(imemDepth)-1:0] imemAddr,
	input cpuPkg::instrT imemData,
	output cpuPkg::instrT ifIdInstr
);
	import cpuPkg::*;

	localparam int pcW = $clog2(imemDepth);

	instrT imem [imemDepth];
	logic [pcW-1:0] pc;

	// Program load only while the core sits in reset
	always_ff @(posedge clk) begin
		if (imemWe && !rstN) begin
			imem[imemAddr] <= imemData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
			ifIdInstr <= '0;
		end else if (branchTaken) begin
			// Drop the instruction being fetched, restart at target
			pc <= branchTarget[pcW-1:0];
			ifIdInstr <= '0;
		end else if (!stall) begin
			pc <= pc + 1'b1;
			ifIdInstr <= imem[pc];
		end
	end

	assert property (@(posedge clk) imemWe |-> !rstN)
		else $error("instruction load strobe while core is running");

endmodule

// ==== executeStage.sv ====
module executeStage (
	input logic clk,
	input logic rstN,
	input cpuPkg::idExT idEx,
	input cpuPkg::fwdSelE fwdSrc,
	input cpuPkg::fwdSelE fwdDst,
	input logic [cpuPkg::dataWidth-1:0] exMemResult,
	input logic [cpuPkg::dataWidth-1:0] wbData,
	output cpuPkg::exMemT exMem,
	output logic branchTaken,
	output logic [cpuPkg::dataWidth-1:0] branchTarget
);
	import cpuPkg::*;

	logic [dataWidth-1:0] srcOp;
	logic [dataWidth-1:0] dstOp;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] result;
	logic carry;
	logic condMet;
	flagsT flagsQ;
	flagsT flagsNext;

	function automatic logic [dataWidth-1:0] fwdValue(
		input fwdSelE sel,
		input logic [dataWidth-1:0] regVal,
		input logic [dataWidth-1:0] exMemVal,
		input logic [dataWidth-1:0] wbVal
	);
		case (sel)
			fwdExMem: return exMemVal;
			fwdMemWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign srcOp = fwdValue(fwdSrc, idEx.srcVal, exMemResult, wbData);
	assign dstOp = fwdValue(fwdDst, idEx.dstVal, exMemResult, wbData);
	assign opA = idEx.ctrl.immToAlu ? idEx.imm : srcOp;

	// Carry only moves on add and sub, sub leaves the borrow
	always_comb begin
		carry = flagsQ.c;
		case (idEx.ctrl.aluOp)
			aluAdd: {carry, result} = {1'b0, dstOp} + {1'b0, opA};
			aluSub: {carry, result} = {1'b0, dstOp} - {1'b0, opA};
			aluAnd: result = dstOp & opA;
			aluOr: result = dstOp | opA;
			aluNot: result = ~opA;
			default: result = opA;
		endcase
	end

	assign flagsNext = '{z: (result == '0), n: result[dataWidth-1], c: carry};

	always_ff @(posedge clk) begin
		if (!rstN) begin
			flagsQ <= '0;
		end else if (idEx.ctrl.updateFlags) begin
			flagsQ <= flagsNext;
		end
	end

	// Flags of the ALU op just ahead are already in flagsQ by now
	always_comb begin
		case (idEx.fun)
			condZero: condMet = flagsQ.z;
			condNeg: condMet = flagsQ.n;
			condCarry: condMet = flagsQ.c;
			default: condMet = 1'b0;
		endcase
	end

	assign branchTaken = idEx.ctrl.branch && (idEx.ctrl.uncond || condMet);
	assign branchTarget = dstOp;

	always_comb begin
		exMem.regWrite = idEx.ctrl.regWrite;
		exMem.memRead = idEx.ctrl.memRead;
		exMem.memWrite = idEx.ctrl.memWrite;
		exMem.memToReg = idEx.ctrl.memToReg;
		exMem.dst = idEx.dstAddr;
		exMem.aluResult = result;
		exMem.storeData = dstOp;
	end

	// A taken jump leaves a bubble behind it in execute
	assert property (@(posedge clk) disable iff (!rstN)
		branchTaken |-> idEx.ctrl.branch ##1 (idEx.ctrl == '0))
		else $error("taken jump not followed by a bubble");

endmodule

// ==== memoryStage.sv ====
module memoryStage #(
	parameter int dmemDepth = 32
) (
	input logic clk,
	input cpuPkg::exMemT exMem,
	output logic [cpuPkg::dataWidth-1:0] memData
);
	import cpuPkg::*;

	localparam int addrW = $clog2(dmemDepth);

	logic [dataWidth-1:0] dmem [dmemDepth];
	logic [addrW-1:0] addr;

	assign addr = exMem.aluResult[addrW-1:0];

	always_ff @(posedge clk) begin
		if (exMem.memWrite) begin
			dmem[addr] <= exMem.storeData;
		end
	end

	// read is combinational, MEM/WB captures it
	assign memData = dmem[addr];

	assert property (@(posedge clk) not (exMem.memRead && exMem.memWrite))
		else $error("load and store in the same memory cycle");

endmodule

// ==== pipelineCpu.sv ====
module pipelineCpu #(
	parameter int imemDepth = 64,
	parameter int dmemDepth = 32
) (
	input logic clk,
	input logic rstN,
	input logic imemWe,
	input logic [$clog2(imemDepth)-1:0] imemAddr,
	input cpuPkg::instrT imemData,
	output logic wbValid,
	output logic [3:0] wbAddr,
	output logic [cpuPkg::dataWidth-1:0] wbData
);
	import cpuPkg::*;

	instrT ifIdInstr;
	ctrlT idCtrl;
	logic [dataWidth-1:0] idSrcVal;
	logic [dataWidth-1:0] idDstVal;
	logic stall;
	logic flush;
	logic idBubble;
	logic branchTaken;
	logic [dataWidth-1:0] branchTarget;
	fwdSelE fwdSrc;
	fwdSelE fwdDst;
	idExT idExD;
	idExT idExQ;
	exMemT exMemD;
	exMemT exMemQ;
	memWbT memWbD;
	memWbT memWbQ;
	logic [dataWidth-1:0] memData;

	assign flush = branchTaken;
	assign idBubble = stall || flush;

	fetchStage #(.imemDepth(imemDepth)) fetch (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.ifIdInstr(ifIdInstr)
	);

	controlUnit ctrlUnit (
		.instr(ifIdInstr),
		.bubble(idBubble),
		.ctrl(idCtrl)
	);

	regFile regs (
		.clk(clk),
		.rstN(rstN),
		.we(memWbQ.regWrite),
		.waddr(memWbQ.dst),
		.wdata(wbData),
		.raddrA(ifIdInstr.src),
		.raddrB(ifIdInstr.dst),
		.rdataA(idSrcVal),
		.rdataB(idDstVal)
	);

	// Decode field split
	always_comb begin
		idExD.ctrl = idCtrl;
		idExD.fun = ifIdInstr.fun;
		idExD.srcAddr = ifIdInstr.src;
		idExD.dstAddr = ifIdInstr.dst;
		idExD.srcVal = idSrcVal;
		idExD.dstVal = idDstVal;
		idExD.imm = {{(dataWidth - 7){1'b0}}, ifIdInstr.src, ifIdInstr.fun};
	end

	hazardUnit hazard (
		.clk(clk),
		.rstN(rstN),
		.idSrc(ifIdInstr.src),
		.idDst(ifIdInstr.dst),
		.exMemRead(idExQ.ctrl.memRead),
		.exDst(idExQ.dstAddr),
		.exSrc(idExQ.srcAddr),
		.exMemRegWrite(exMemQ.regWrite),
		.exMemDst(exMemQ.dst),
		.memWbRegWrite(memWbQ.regWrite),
		.memWbDst(memWbQ.dst),
		.stall(stall),
		.fwdSrc(fwdSrc),
		.fwdDst(fwdDst)
	);

	pipeReg #(.payloadT(idExT)) idExReg (
		.clk(clk),
		.rstN(rstN),
		.bubble(idBubble),
		.d(idExD),
		.q(idExQ)
	);

	executeStage execute (
		.clk(clk),
		.rstN(rstN),
		.idEx(idExQ),
		.fwdSrc(fwdSrc),
		.fwdDst(fwdDst),
		.exMemResult(exMemQ.aluResult),
		.wbData(wbData),
		.exMem(exMemD),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

	pipeReg #(.payloadT(exMemT)) exMemReg (
		.clk(clk),
		.rstN(rstN),
		.bubble(1'b0),
		.d(exMemD),
		.q(exMemQ)
	);

	memoryStage #(.dmemDepth(dmemDepth)) memStage (
		.clk(clk),
		.exMem(exMemQ),
		.memData(memData)
	);

	always_comb begin
		memWbD.regWrite = exMemQ.regWrite;
		memWbD.memToReg = exMemQ.memToReg;
		memWbD.dst = exMemQ.dst;
		memWbD.aluResult = exMemQ.aluResult;
		memWbD.memData = memData;
	end

	pipeReg #(.payloadT(memWbT)) memWbReg (
		.clk(clk),
		.rstN(rstN),
		.bubble(1'b0),
		.d(memWbD),
		.q(memWbQ)
	);

	// Write-back mux feeds the register file, forwarding and the port
	assign wbData = memWbQ.memToReg ? memWbQ.memData : memWbQ.aluResult;
	assign wbValid = memWbQ.regWrite;
	assign wbAddr = memWbQ.dst;

endmodule

// ==== cpuTb.sv ====
module cpuTb;
	import cpuPkg::*;

	localparam int imemDepth = 64;
	localparam int dmemDepth = 32;
	localparam int vecDepth = 1024;
	localparam int resetCycles = 8;
	localparam int settleCycles = 12;

	logic clk;
	logic rstN;
	logic imemWe;
	logic [$clog2(imemDepth)-1:0] imemAddr;
	instrT imemData;
	logic wbValid;
	logic [3:0] wbAddr;
	logic [dataWidth-1:0] wbData;

	logic [15:0] vec [vecDepth];
	int testBase [$];
	int totalInstr;
	int cycleLimit;
	int runCycles;
	int errors;
	int testsFailed;
	// Expectations of the test in progress
	int expBase;
	int numWb;
	int wbIdx;
	int testErrors;

	pipelineCpu #(
		.imemDepth(imemDepth),
		.dmemDepth(dmemDepth)
	) dut (
		.clk(clk),
		.rstN(rstN),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rstN === 1'b1) begin
			runCycles++;
		end
		if (runCycles > cycleLimit) begin
			$display("Timeout: no progress after %0d running cycles", runCycles);
			$display("Verification failed");
			$finish;
		end
	end

	// Unused words are NOPs or loads of random values, never retired
	function automatic instrT fillerWord();
		instrT w;
		w = '0;
		if ($urandom % 2) begin
			w.opcode = opLdm;
			w.src = 4'($urandom);
			w.dst = 4'($urandom);
			w.fun = 3'($urandom);
		end
		return w;
	endfunction

	task automatic checkWriteBack();
		logic [3:0] expAddr;
		logic [dataWidth-1:0] expData;
		assert (!$isunknown(wbValid)) else begin
			$display("wbValid is unknown at time %0t", $time);
			testErrors++;
		end
		if (wbValid === 1'b1) begin
			assert (wbIdx < numWb) else begin
				$display("Extra write-back to r%0d at time %0t after the expected list ended",
					wbAddr, $time);
				testErrors++;
			end
			if (wbIdx < numWb) begin
				expAddr = vec[expBase + 2 * wbIdx][3:0];
				expData = vec[expBase + 2 * wbIdx + 1];
				assert (wbAddr === expAddr) else begin
					$display("Mismatch at time %0t: wbAddr expected %h, actual %h",
						$time, expAddr, wbAddr);
					testErrors++;
				end
				assert (wbData === expData) else begin
					$display("Mismatch at time %0t: wbData expected %h, actual %h",
						$time, expData, wbData);
					testErrors++;
				end
				wbIdx++;
			end
		end
	endtask

	// Caller has already pulled rstN low on a falling edge
	task automatic holdReset(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (wbValid === 1'b0) else begin
				$display("Write-back to r%0d at time %0t while rstN was low", wbAddr, $time);
				testErrors++;
			end
		end
		rstN = 1'b1;
	endtask

	task automatic loadProgram(input int base, input int numInstr);
		int a;
		rstN = 1'b0;
		for (a = 0; a < imemDepth; a++) begin
			@(negedge clk);
			imemWe = 1'b1;
			imemAddr = a[$clog2(imemDepth)-1:0];
			imemData = (a < numInstr) ? instrT'(vec[base + a]) : fillerWord();
		end
		@(negedge clk);
		imemWe = 1'b0;
	endtask

	task automatic runTest(input int idx, input int base);
		int numInstr;
		int resetAfter;
		int waited;
		bit resetDone;
		numInstr = vec[base];
		numWb = vec[base + 1];
		resetAfter = vec[base + 2];
		expBase = base + 3 + numInstr;
		wbIdx = 0;
		testErrors = 0;
		waited = 0;
		resetDone = 1'b0;
		loadProgram(base + 3, numInstr);
		holdReset(resetCycles);
		while (wbIdx < numWb && waited < 8 * numInstr) begin
			@(negedge clk);
			checkWriteBack();
			waited++;
			if (!resetDone && resetAfter != 0 && wbIdx == resetAfter) begin
				resetDone = 1'b1;
				rstN = 1'b0;
				holdReset(resetCycles);
			end
		end
		// Halt loop at the end of every program, nothing more may retire
		repeat (settleCycles) begin
			@(negedge clk);
			checkWriteBack();
		end
		assert (wbIdx == numWb) else begin
			$display("Missing write-backs: only %0d of %0d arrived", wbIdx, numWb);
			testErrors++;
		end
		$display("Test %0d: %0d instructions, %0d of %0d write-backs, %0d errors",
			idx, numInstr, wbIdx, numWb, testErrors);
		errors += testErrors;
		if (testErrors != 0) begin
			testsFailed++;
		end
	endtask

	initial begin
		int ptr;
		int t;
		rstN = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		errors = 0;
		testsFailed = 0;
		totalInstr = 0;
		runCycles = 0;
		cycleLimit = 100;
		void'($urandom(32'hf0a4_009d));
		$readmemh("cpuVectors.txt", vec);
		ptr = 0;
		while (ptr < vecDepth - 3 && !$isunknown(vec[ptr]) && vec[ptr] != 16'h0000) begin
			testBase.push_back(ptr);
			totalInstr += vec[ptr];
			ptr += 3 + vec[ptr] + 2 * vec[ptr + 1];
		end
		cycleLimit = 8 * totalInstr + 100;
		assert (testBase.size() > 0) else begin
			$display("No test programs could be read from cpuVectors.txt");
			errors++;
		end
		for (t = 0; t < testBase.size(); t++) begin
			runTest(t, testBase[t]);
		end
		$display("Summary: %0d tests, %0d failed, %0d errors",
			testBase.size(), testsFailed, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== cpuVectors.txt ====
// Test header: instruction count, write-back count, write-backs before a second reset (0: none)
// Then the program words, then the expected write-backs as register/data pairs; 0 0 0 ends

// ALU functions, immediates and 16-bit wraparound
000c 000b 0000
178f 1015 1318 08a5 08a0 0920 0991 089a 090b 09ac 10fb 3078
0001 007f 0002 0005 0003 0030 0004 ff80 0004 ffff 0004 0004
0002 ffd5 0003 0030 0001 ffff 0005 0030 000f 000b

// Forwarding at distances one, two and three
000c 000b 0000
100b 1015 0890 1019 0991 1022 102c 0a90 0934 0a31 10fb 3078
0001 0003 0002 0005 0002 0008 0003 0001 0002 0007 0004 0002
0005 0004 0002 000b 0006 000b 0006 0009 000f 000b

// Store, load and load-use stalls
0009 0007 0000
100f 1592 2090 1898 0918 18a0 0a2c 10f8 3078
0001 0007 0002 005a 0003 005a 0003 00b4 0004 005a 0005 005a 000f 0008

// Jumps, taken and not-taken conditional jumps on z, n and c
001b 000c 0000
100d 1011 3008 1119 121a 0911 108a 2808 1323 1424 1029 0a91 2808 1109
2809 1636 1737 0aa8 1188 280a 0a90 280a 1039 103a 0944 11fa 3078
0001 0005 0002 0001 0002 0000 0001 000a 0005 0001 0002 ffff
0001 0011 0005 0002 0001 0018 0002 0001 0008 0001 000f 001a

// Second reset after three write-backs, program restarts with cleared registers
0006 0008 0003
0a18 151d 10a2 0a18 107d 3078
0003 0000 0003 0055 0004 000a 0003 0000 0003 0055 0004 000a 0003 005f 000f 0005

0000 0000 0000

// ==== src.f ====
cpuPkg.sv
pipeReg.sv
regFile.sv
controlUnit.sv
hazardUnit.sv
fetchStage.sv
executeStage.sv
memoryStage.sv
pipelineCpu.sv
cpuTb.sv
